// ==== ao_peripheral_subsystem.f ====
hdl/ao_periph_pkg.sv
hdl/obi_to_reg.sv
hdl/reg_demux.sv
hdl/soc_ctrl.sv
hdl/fast_intr_ctrl.sv
hdl/rv_timer.sv
hdl/ao_peripheral_subsystem.sv
test/tb_ao_peripheral_subsystem.sv

// ==== hdl/ao_periph_pkg.sv ====
/* Address map, register offsets and byte-enable merge helper shared by
   the always-on peripheral subsystem modules */

`default_nettype none

package ao_periph_pkg;

  // Slave targeted by a register bus address
  typedef enum logic [1:0] {
    SEL_SOC_CTRL  = 2'd0,
    SEL_FAST_INTR = 2'd1,
    SEL_TIMER     = 2'd2,
    SEL_NONE      = 2'd3
  } periph_sel_e;

  // 4 KiB windows, decoded on bits 31:12
  localparam logic [31:0] SOC_CTRL_BASE  = 32'h2000_0000;
  localparam logic [31:0] FAST_INTR_BASE = 32'h2000_1000;
  localparam logic [31:0] TIMER_BASE     = 32'h2000_2000;

  localparam logic [11:0] SOC_EXIT_VALID  = 12'h000;
  localparam logic [11:0] SOC_EXIT_VALUE  = 12'h004;
  localparam logic [11:0] SOC_BOOT_SELECT = 12'h008;

  localparam logic [11:0] FIC_PENDING = 12'h000;
  localparam logic [11:0] FIC_ENABLE  = 12'h004;

  localparam logic [11:0] TMR_CTRL     = 12'h000;
  localparam logic [11:0] TMR_PRESCALE = 12'h004;
  localparam logic [11:0] TMR_MTIME    = 12'h008;
  localparam logic [11:0] TMR_MTIMECMP = 12'h00C;

  // Byte-wise merge of new data over an old value
  function automatic logic [31:0] apply_be(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] merged;
    for (int i = 0; i < 4; i++) begin
      merged[8*i+:8] = be[i] ? new_val[8*i+:8] : old_val[8*i+:8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/ao_peripheral_subsystem.sv ====
/* Always-on peripheral subsystem top. OBI-style slave port bridged to a
   register bus that serves SoC control, fast interrupts and the timer */

`default_nettype none

module ao_peripheral_subsystem #(
  parameter int NUM_FAST_INTR = 15
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic                     bus_req_i,
  input  wire logic [31:0]              bus_addr_i,
  input  wire logic                     bus_we_i,
  input  wire logic [3:0]               bus_be_i,
  input  wire logic [31:0]              bus_wdata_i,
  output logic                          bus_gnt_o,
  output logic                          bus_rvalid_o,
  output logic [31:0]                   bus_rdata_o,
  input  wire logic                     boot_select_i,
  output logic                          exit_valid_o,
  output logic [31:0]                   exit_value_o,
  input  wire logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0]      fast_intr_o,
  output logic                          timer_intr_o
);

  logic        reg_valid;
  logic        reg_write;
  logic [31:0] reg_addr;
  logic [3:0]  reg_be;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        soc_valid;
  logic        fic_valid;
  logic        tmr_valid;
  logic [31:0] soc_rdata;
  logic [31:0] fic_rdata;
  logic [31:0] tmr_rdata;

  obi_to_reg i_obi_to_reg (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_addr_i,
    .bus_we_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_be_o    (reg_be),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  reg_demux i_reg_demux (
    .reg_valid_i (reg_valid),
    .reg_addr_i  (reg_addr),
    .reg_rdata_o (reg_rdata),
    .soc_valid_o (soc_valid),
    .fic_valid_o (fic_valid),
    .tmr_valid_o (tmr_valid),
    .soc_rdata_i (soc_rdata),
    .fic_rdata_i (fic_rdata),
    .tmr_rdata_i (tmr_rdata)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .valid_i       (soc_valid),
    .write_i       (reg_write),
    .addr_i        (reg_addr[11:0]),
    .be_i          (reg_be),
    .wdata_i       (reg_wdata),
    .rdata_o       (soc_rdata),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl #(
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) i_fast_intr_ctrl (
    .clk_i,
    .rst_n_i,
    .valid_i     (fic_valid),
    .write_i     (reg_write),
    .addr_i      (reg_addr[11:0]),
    .be_i        (reg_be),
    .wdata_i     (reg_wdata),
    .rdata_o     (fic_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

  rv_timer i_rv_timer (
    .clk_i,
    .rst_n_i,
    .valid_i      (tmr_valid),
    .write_i      (reg_write),
    .addr_i       (reg_addr[11:0]),
    .be_i         (reg_be),
    .wdata_i      (reg_wdata),
    .rdata_o      (tmr_rdata),
    .timer_intr_o
  );

endmodule

`default_nettype wire

// ==== hdl/fast_intr_ctrl.sv ====
/* Fast interrupt controller. Sticky pending bits set by the inputs,
   cleared by writing ones, and masked by an enable register */

`default_nettype none

module fast_intr_ctrl
  import ao_periph_pkg::*;
#(
  parameter int NUM_FAST_INTR = 15
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic                     valid_i,
  input  wire logic                     write_i,
  input  wire logic [11:0]              addr_i,
  input  wire logic [3:0]               be_i,
  input  wire logic [31:0]              wdata_i,
  output logic [31:0]                   rdata_o,
  input  wire logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0]      fast_intr_o
);

  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;
  logic [31:0]              clr_mask;
  logic [31:0]              enable_merged;
  logic                     wr_pending;
  logic                     wr_enable;

  assign wr_pending    = valid_i & write_i & (addr_i == FIC_PENDING);
  assign wr_enable     = valid_i & write_i & (addr_i == FIC_ENABLE);
  assign clr_mask      = wr_pending ? apply_be(32'h0, wdata_i, be_i) : 32'h0;
  assign enable_merged = apply_be(32'(enable_q), wdata_i, be_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live input wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr_mask[NUM_FAST_INTR-1:0]) | fast_intr_i;
      if (wr_enable) begin
        enable_q <= enable_merged[NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    case (addr_i)
      FIC_PENDING: rdata_o = 32'(pending_q);
      FIC_ENABLE:  rdata_o = 32'(enable_q);
      default:     rdata_o = 32'h0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

`default_nettype wire

// ==== hdl/obi_to_reg.sv ====
/* OBI-style slave to single-cycle register bus bridge. Grants every
   request and returns the response one cycle after acceptance */

`default_nettype none

module obi_to_reg (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        bus_req_i,
  input  wire logic [31:0] bus_addr_i,
  input  wire logic        bus_we_i,
  input  wire logic [3:0]  bus_be_i,
  input  wire logic [31:0] bus_wdata_i,
  output logic             bus_gnt_o,
  output logic             bus_rvalid_o,
  output logic [31:0]      bus_rdata_o,
  output logic             reg_valid_o,
  output logic             reg_write_o,
  output logic [31:0]      reg_addr_o,
  output logic [3:0]       reg_be_o,
  output logic [31:0]      reg_wdata_o,
  input  wire logic [31:0] reg_rdata_i
);

  logic        rvalid_q;
  logic [31:0] rdata_q;

  // Slaves never stall, so grant follows request
  assign bus_gnt_o   = bus_req_i;
  assign reg_valid_o = bus_req_i;
  assign reg_write_o = bus_we_i;
  assign reg_addr_o  = bus_addr_i;
  assign reg_be_o    = bus_be_i;
  assign reg_wdata_o = bus_wdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i;
    end
  end

  // Writes answer with zero
  always_ff @(posedge clk_i) begin
    if (bus_req_i) begin
      rdata_q <= bus_we_i ? 32'h0 : reg_rdata_i;
    end
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/reg_demux.sv ====
/* Register bus address decoder. Steers the valid strobe to one slave and
   returns its read data, absorbing unmapped accesses */

`default_nettype none

module reg_demux
  import ao_periph_pkg::*;
(
  input  wire logic        reg_valid_i,
  input  wire logic [31:0] reg_addr_i,
  output logic [31:0]      reg_rdata_o,
  output logic             soc_valid_o,
  output logic             fic_valid_o,
  output logic             tmr_valid_o,
  input  wire logic [31:0] soc_rdata_i,
  input  wire logic [31:0] fic_rdata_i,
  input  wire logic [31:0] tmr_rdata_i
);

  periph_sel_e sel;

  always_comb begin
    if (reg_addr_i[31:12] == SOC_CTRL_BASE[31:12]) begin
      sel = SEL_SOC_CTRL;
    end else if (reg_addr_i[31:12] == FAST_INTR_BASE[31:12]) begin
      sel = SEL_FAST_INTR;
    end else if (reg_addr_i[31:12] == TIMER_BASE[31:12]) begin
      sel = SEL_TIMER;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign soc_valid_o = reg_valid_i & (sel == SEL_SOC_CTRL);
  assign fic_valid_o = reg_valid_i & (sel == SEL_FAST_INTR);
  assign tmr_valid_o = reg_valid_i & (sel == SEL_TIMER);

  // Unmapped reads return zero
  always_comb begin
    case (sel)
      SEL_SOC_CTRL:  reg_rdata_o = soc_rdata_i;
      SEL_FAST_INTR: reg_rdata_o = fic_rdata_i;
      SEL_TIMER:     reg_rdata_o = tmr_rdata_i;
      default:       reg_rdata_o = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rv_timer.sv ====
/* Machine timer with prescaler. mtime advances every PRESCALE+1 cycles
   while enabled and a registered compare raises the interrupt */

`default_nettype none

module rv_timer
  import ao_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        valid_i,
  input  wire logic        write_i,
  input  wire logic [11:0] addr_i,
  input  wire logic [3:0]  be_i,
  input  wire logic [31:0] wdata_i,
  output logic [31:0]      rdata_o,
  output logic             timer_intr_o
);

  logic        enable_q;
  logic [31:0] prescale_q;
  logic [31:0] presc_cnt_q;
  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        intr_q;
  logic [31:0] ctrl_merged;
  logic        wr;
  logic        tick;

  assign wr          = valid_i & write_i;
  assign ctrl_merged = apply_be({31'h0, enable_q}, wdata_i, be_i);
  assign tick        = enable_q & (presc_cnt_q == prescale_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= 32'h0;
      presc_cnt_q <= 32'h0;
      mtime_q     <= 32'h0;
      mtimecmp_q  <= 32'h0;
      intr_q      <= 1'b0;
    end else begin
      if (wr && addr_i == TMR_CTRL) begin
        enable_q <= ctrl_merged[0];
      end
      if (wr && addr_i == TMR_PRESCALE) begin
        prescale_q <= apply_be(prescale_q, wdata_i, be_i);
      end
      if (wr && addr_i == TMR_MTIMECMP) begin
        mtimecmp_q <= apply_be(mtimecmp_q, wdata_i, be_i);
      end
      // Prescaler restarts from zero when disabled
      if (!enable_q || tick) begin
        presc_cnt_q <= 32'h0;
      end else begin
        presc_cnt_q <= presc_cnt_q + 32'd1;
      end
      // Software write overrides the increment
      if (wr && addr_i == TMR_MTIME) begin
        mtime_q <= apply_be(mtime_q, wdata_i, be_i);
      end else if (tick) begin
        mtime_q <= mtime_q + 32'd1;
      end
      intr_q <= enable_q & (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (addr_i)
      TMR_CTRL:     rdata_o = {31'h0, enable_q};
      TMR_PRESCALE: rdata_o = prescale_q;
      TMR_MTIME:    rdata_o = mtime_q;
      TMR_MTIMECMP: rdata_o = mtimecmp_q;
      default:      rdata_o = 32'h0;
    endcase
  end

  assign timer_intr_o = intr_q;

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl.sv ====
/* SoC control registers: sticky simulation exit flag, exit value and
   boot select readback */

`default_nettype none

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        valid_i,
  input  wire logic        write_i,
  input  wire logic [11:0] addr_i,
  input  wire logic [3:0]  be_i,
  input  wire logic [31:0] wdata_i,
  output logic [31:0]      rdata_o,
  input  wire logic        boot_select_i,
  output logic             exit_valid_o,
  output logic [31:0]      exit_value_o
);

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] valid_merged;
  logic        wr_exit_valid;
  logic        wr_exit_value;

  assign wr_exit_valid = valid_i & write_i & (addr_i == SOC_EXIT_VALID);
  assign wr_exit_value = valid_i & write_i & (addr_i == SOC_EXIT_VALUE);
  assign valid_merged  = apply_be({31'h0, exit_valid_q}, wdata_i, be_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
    end else begin
      // Once set, only reset clears it
      if (wr_exit_valid && valid_merged[0]) begin
        exit_valid_q <= 1'b1;
      end
      if (wr_exit_value) begin
        exit_value_q <= apply_be(exit_value_q, wdata_i, be_i);
      end
    end
  end

  always_comb begin
    case (addr_i)
      SOC_EXIT_VALID:  rdata_o = {31'h0, exit_valid_q};
      SOC_EXIT_VALUE:  rdata_o = exit_value_q;
      SOC_BOOT_SELECT: rdata_o = {31'h0, boot_select_i};
      default:         rdata_o = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# Exits non-zero unless the pass line appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ao_peripheral_subsystem \
  -f ao_peripheral_subsystem.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// ==== test/tb_ao_peripheral_subsystem.sv ====
/* Table-driven testbench for the always-on peripheral subsystem. Runs bus
   accesses, interrupt pulses and pin checks from one table in order */

`default_nettype none

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FAST_INTR = 15;

  localparam logic [31:0] A_EXIT_VALID  = SOC_CTRL_BASE + 32'(SOC_EXIT_VALID);
  localparam logic [31:0] A_EXIT_VALUE  = SOC_CTRL_BASE + 32'(SOC_EXIT_VALUE);
  localparam logic [31:0] A_BOOT_SELECT = SOC_CTRL_BASE + 32'(SOC_BOOT_SELECT);
  localparam logic [31:0] A_FIC_PENDING = FAST_INTR_BASE + 32'(FIC_PENDING);
  localparam logic [31:0] A_FIC_ENABLE  = FAST_INTR_BASE + 32'(FIC_ENABLE);
  localparam logic [31:0] A_TMR_CTRL    = TIMER_BASE + 32'(TMR_CTRL);
  localparam logic [31:0] A_TMR_PRESC   = TIMER_BASE + 32'(TMR_PRESCALE);
  localparam logic [31:0] A_TMR_MTIME   = TIMER_BASE + 32'(TMR_MTIME);
  localparam logic [31:0] A_TMR_CMP     = TIMER_BASE + 32'(TMR_MTIMECMP);
  localparam logic [31:0] A_UNMAPPED    = 32'h2000_3000;

  typedef enum int {
    OP_WR, OP_RD, OP_RD_GE, OP_B2B, OP_PULSE, OP_WAIT_IRQ,
    OP_EXIT_VALID, OP_EXIT_VALUE, OP_FAST, OP_TIMER
  } op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp;
  } entry_t;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  logic                     bus_req_i;
  logic [31:0]              bus_addr_i;
  logic                     bus_we_i;
  logic [3:0]               bus_be_i;
  logic [31:0]              bus_wdata_i;
  logic                     bus_gnt_o;
  logic                     bus_rvalid_o;
  logic [31:0]              bus_rdata_o;
  logic                     boot_select_i;
  logic                     exit_valid_o;
  logic [31:0]              exit_value_o;
  logic [NUM_FAST_INTR-1:0] fast_intr_i;
  logic [NUM_FAST_INTR-1:0] fast_intr_o;
  logic                     timer_intr_o;

  entry_t      table_q[$];
  logic [31:0] resp_q[$];
  int          table_len = 0;
  int          errors = 0;
  int          checks = 0;
  int          seed;
  logic [31:0] rand_full;
  logic [31:0] rand_part;
  logic [31:0] rand_unmapped;
  logic [31:0] rand_b2b;

  ao_peripheral_subsystem #(
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) i_ao_peripheral_subsystem (
    .clk_i,
    .rst_n_i,
    .bus_req_i,
    .bus_addr_i,
    .bus_we_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o,
    .fast_intr_i,
    .fast_intr_o,
    .timer_intr_o
  );

  always #4 clk_i = ~clk_i;

  task automatic add_entry(input string name, input op_e op, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] exp);
    entry_t e;
    e.name  = name;
    e.op    = op;
    e.addr  = addr;
    e.be    = be;
    e.wdata = wdata;
    e.exp   = exp;
    table_q.push_back(e);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // One request, then wait for its response on the falling edge
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic ok);
    int waited;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    @(negedge clk_i);
    assert (bus_gnt_o === 1'b1) else begin
      report_error("The DUT did not grant a pending request");
    end
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!bus_rvalid_o && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    ok    = bus_rvalid_o;
    rdata = bus_rdata_o;
  endtask

  // Write accepted at one edge, read of the same address at the next
  task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata);
    resp_q.delete();
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= 1'b1;
    bus_addr_i  <= addr;
    bus_be_i    <= 4'hf;
    bus_wdata_i <= wdata;
    for (int step = 0; step < 4; step++) begin
      @(posedge clk_i);
      if (step == 0) begin
        bus_we_i <= 1'b0;
      end
      if (step == 1) begin
        bus_req_i <= 1'b0;
      end
      @(negedge clk_i);
      if (bus_rvalid_o) begin
        resp_q.push_back(bus_rdata_o);
      end
    end
  endtask

  task automatic pulse_fast_intr(input logic [NUM_FAST_INTR-1:0] bits);
    @(posedge clk_i);
    fast_intr_i <= bits;
    @(posedge clk_i);
    fast_intr_i <= '0;
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    logic        ok;
    int          err_before;
    int          waited;
    err_before = errors;
    case (e.op)
      OP_WR, OP_RD, OP_RD_GE: begin
        bus_access(e.op == OP_WR, e.addr, e.be, e.wdata, rdata, ok);
        if (!ok) begin
          report_error($sformatf("%s: no response from the DUT", e.name));
        end else if (e.op == OP_RD_GE) begin
          checks++;
          assert (rdata >= e.exp) else begin
            $display("CHECK FAILED %s: expected at least %h, actual %h", e.name, e.exp, rdata);
            errors++;
          end
        end else begin
          check_value(e.name, e.exp, rdata);
        end
      end
      OP_B2B: begin
        write_then_read(e.addr, e.wdata);
        if (resp_q.size() != 2) begin
          report_error($sformatf("%s: got %0d responses for two requests", e.name,
                                 resp_q.size()));
        end else begin
          check_value($sformatf("%s write", e.name), 32'h0, resp_q[0]);
          check_value(e.name, e.exp, resp_q[1]);
        end
      end
      OP_PULSE: pulse_fast_intr(e.wdata[NUM_FAST_INTR-1:0]);
      OP_WAIT_IRQ: begin
        // wdata holds the longest wait, exp the shortest plausible one
        waited = 0;
        while (!timer_intr_o && waited < int'(e.wdata)) begin
          @(negedge clk_i);
          waited++;
        end
        if (!timer_intr_o) begin
          report_error($sformatf("%s: timer interrupt never rose", e.name));
        end else begin
          checks++;
          assert (waited >= int'(e.exp)) else begin
            $display("CHECK FAILED %s: expected at least %0d low cycles, actual %0d",
                     e.name, e.exp, waited);
            errors++;
          end
        end
      end
      OP_EXIT_VALID: begin
        @(negedge clk_i);
        check_value(e.name, e.exp, 32'(exit_valid_o));
      end
      OP_EXIT_VALUE: begin
        @(negedge clk_i);
        check_value(e.name, e.exp, exit_value_o);
      end
      OP_FAST: begin
        @(negedge clk_i);
        check_value(e.name, e.exp, 32'(fast_intr_o));
      end
      default: begin
        @(negedge clk_i);
        check_value(e.name, e.exp, 32'(timer_intr_o));
      end
    endcase
    $display("%-28s %s", e.name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin
    wait (table_len > 0);
    #((table_len * 10 + 2000) * 8);
    $display("Timeout: the run did not finish within %0d cycles", table_len * 10 + 2000);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed          = 32'hb746;
    rand_full     = $random(seed);
    rand_part     = $random(seed);
    rand_unmapped = $random(seed);
    rand_b2b      = $random(seed);

    add_entry("reset_exit_valid_pin", OP_EXIT_VALID, 32'h0, 4'h0, 32'h0, 32'h0);
    add_entry("reset_fast_intr_pin", OP_FAST, 32'h0, 4'h0, 32'h0, 32'h0);
    add_entry("reset_timer_pin", OP_TIMER, 32'h0, 4'h0, 32'h0, 32'h0);
    add_entry("reset_exit_valid", OP_RD, A_EXIT_VALID, 4'hf, 32'h0, 32'h0);
    add_entry("reset_exit_value", OP_RD, A_EXIT_VALUE, 4'hf, 32'h0, 32'h0);
    add_entry("reset_boot_select", OP_RD, A_BOOT_SELECT, 4'hf, 32'h0, 32'h1);
    add_entry("reset_fic_pending", OP_RD, A_FIC_PENDING, 4'hf, 32'h0, 32'h0);
    add_entry("reset_fic_enable", OP_RD, A_FIC_ENABLE, 4'hf, 32'h0, 32'h0);
    add_entry("reset_tmr_ctrl", OP_RD, A_TMR_CTRL, 4'hf, 32'h0, 32'h0);
    add_entry("reset_tmr_prescale", OP_RD, A_TMR_PRESC, 4'hf, 32'h0, 32'h0);
    add_entry("reset_tmr_mtime", OP_RD, A_TMR_MTIME, 4'hf, 32'h0, 32'h0);
    add_entry("reset_tmr_mtimecmp", OP_RD, A_TMR_CMP, 4'hf, 32'h0, 32'h0);

    add_entry("exit_value_write", OP_WR, A_EXIT_VALUE, 4'hf, rand_full, 32'h0);
    add_entry("exit_value_read", OP_RD, A_EXIT_VALUE, 4'hf, 32'h0, rand_full);
    add_entry("exit_value_pin", OP_EXIT_VALUE, 32'h0, 4'h0, 32'h0, rand_full);
    add_entry("exit_value_partial_write", OP_WR, A_EXIT_VALUE, 4'b0101, rand_part, 32'h0);
    // Bytes 0 and 2 come from the new word, bytes 1 and 3 are kept
    add_entry("exit_value_partial_read", OP_RD, A_EXIT_VALUE, 4'hf, 32'h0,
              (rand_full & 32'hff00_ff00) | (rand_part & 32'h00ff_00ff));
    add_entry("exit_valid_write", OP_WR, A_EXIT_VALID, 4'hf, 32'h1, 32'h0);
    add_entry("exit_valid_pin", OP_EXIT_VALID, 32'h0, 4'h0, 32'h0, 32'h1);
    add_entry("exit_valid_read", OP_RD, A_EXIT_VALID, 4'hf, 32'h0, 32'h1);
    add_entry("exit_valid_zero_write", OP_WR, A_EXIT_VALID, 4'hf, 32'h0, 32'h0);
    add_entry("exit_valid_sticky_pin", OP_EXIT_VALID, 32'h0, 4'h0, 32'h0, 32'h1);

    add_entry("unmapped_write", OP_WR, A_UNMAPPED, 4'hf, rand_unmapped, 32'h0);
    add_entry("unmapped_read", OP_RD, A_UNMAPPED, 4'hf, 32'h0, 32'h0);
    add_entry("back_to_back", OP_B2B, A_EXIT_VALUE, 4'hf, rand_b2b, rand_b2b);
    add_entry("back_to_back_pin", OP_EXIT_VALUE, 32'h0, 4'h0, 32'h0, rand_b2b);

    add_entry("fic_enable_write", OP_WR, A_FIC_ENABLE, 4'hf, 32'h0000_4001, 32'h0);
    add_entry("fic_pulse", OP_PULSE, 32'h0, 4'h0, 32'h0000_4003, 32'h0);
    add_entry("fic_pending_read", OP_RD, A_FIC_PENDING, 4'hf, 32'h0, 32'h0000_4003);
    add_entry("fic_masked_pin", OP_FAST, 32'h0, 4'h0, 32'h0, 32'h0000_4001);
    add_entry("fic_clear_write", OP_WR, A_FIC_PENDING, 4'hf, 32'hffff_ffff, 32'h0);
    add_entry("fic_cleared_read", OP_RD, A_FIC_PENDING, 4'hf, 32'h0, 32'h0);
    add_entry("fic_cleared_pin", OP_FAST, 32'h0, 4'h0, 32'h0, 32'h0);
    add_entry("fic_pulse_all", OP_PULSE, 32'h0, 4'h0, 32'h0000_7fff, 32'h0);
    add_entry("fic_pending_bit15_read", OP_RD, A_FIC_PENDING, 4'hf, 32'h0, 32'h0000_7fff);
    add_entry("fic_clear_all", OP_WR, A_FIC_PENDING, 4'hf, 32'hffff_ffff, 32'h0);

    add_entry("tmr_prescale_write", OP_WR, A_TMR_PRESC, 4'hf, 32'd3, 32'h0);
    add_entry("tmr_mtimecmp_write", OP_WR, A_TMR_CMP, 4'hf, 32'd20, 32'h0);
    add_entry("tmr_enable_write", OP_WR, A_TMR_CTRL, 4'hf, 32'h1, 32'h0);
    add_entry("tmr_irq_low_pin", OP_TIMER, 32'h0, 4'h0, 32'h0, 32'h0);
    // 20 ticks of 4 cycles from the enable less a few cycles of slack
    add_entry("tmr_irq_wait", OP_WAIT_IRQ, 32'h0, 4'h0, 32'd200, 32'd76);
    add_entry("tmr_mtime_read", OP_RD_GE, A_TMR_MTIME, 4'hf, 32'h0, 32'd20);
    add_entry("tmr_disable_write", OP_WR, A_TMR_CTRL, 4'hf, 32'h0, 32'h0);
    add_entry("tmr_mtimecmp_max", OP_WR, A_TMR_CMP, 4'hf, 32'hffff_ffff, 32'h0);
    add_entry("tmr_irq_cleared_pin", OP_TIMER, 32'h0, 4'h0, 32'h0, 32'h0);
    table_len = table_q.size();

    rst_n_i       <= 1'b0;
    bus_req_i     <= 1'b0;
    bus_addr_i    <= 32'h0;
    bus_we_i      <= 1'b0;
    bus_be_i      <= 4'h0;
    bus_wdata_i   <= 32'h0;
    boot_select_i <= 1'b1;
    fast_intr_i   <= '0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int i = 0; i < table_len; i++) begin
      run_entry(table_q[i]);
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", table_len, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
